// ==== filelist.f ====
+incdir+logic
logic/tex_coord_pkg.sv
logic/tex_mem_pkg.sv
logic/tex_border_unit.sv
logic/tex_sampler_port.sv
logic/tex_mem_arbiter.sv
logic/tex_memory.sv
logic/tex_sampler_top.sv
tests/tex_clock_gen.sv
tests/tex_sampler_tb.sv

// ==== logic/tex_border_unit.sv ====
// texture border unit
// rounds a fixed point (x, y) to the nearest texel and applies the
// per-axis border operation, result registered one cycle later

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_border_unit
    import tex_coord_pkg::*;
    import tex_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  coord_t      in_x,
    input  coord_t      in_y,
    input  size_t       width,
    input  size_t       height,
    input  border_op_e  x_op,
    input  border_op_e  y_op,
    output logic        out_valid,
    output texel_addr_t out_addr,
    output logic        out_border
);

    // working width for the modulo math, room for 2n and negatives
    localparam int AXIS_W = `TEX_INT_W + 2;
    localparam logic signed [`TEX_FRAC_W:0] ROUND_HALF = 1 << (`TEX_FRAC_W - 1);

    // --------------------------------------------------
    // rounding
    // --------------------------------------------------

    function automatic int_coord_t round_coord(coord_t c);
        logic signed [`TEX_INT_W+`TEX_FRAC_W:0] sum;
        logic signed [`TEX_INT_W:0]             whole;
        sum = c + ROUND_HALF;
        // arithmetic shift by the fraction width
        whole = sum[`TEX_INT_W+`TEX_FRAC_W:`TEX_FRAC_W];
        // only +32 can overflow, saturate it
        if (whole[`TEX_INT_W] != whole[`TEX_INT_W-1]) begin
            return {1'b0, {(`TEX_INT_W-1){1'b1}}};
        end
        return whole[`TEX_INT_W-1:0];
    endfunction

    // --------------------------------------------------
    // per-axis border mapping, returns {border, index}
    // --------------------------------------------------

    function automatic logic [`TEX_ADDR_W:0] map_axis(int_coord_t c, size_t n,
                                                      border_op_e op);
        logic signed [AXIS_W-1:0] cs;
        logic signed [AXIS_W-1:0] ns;
        logic signed [AXIS_W-1:0] n2;
        logic signed [AXIS_W-1:0] m;
        logic                     border;
        cs     = AXIS_W'(c);
        ns     = AXIS_W'(n);
        n2     = ns + ns;
        m      = cs;
        border = 1'b0;
        case (op)
            BORDER_CONST: begin
                border = cs[AXIS_W-1] || (cs >= ns);
            end
            BORDER_CLAMP: begin
                if (cs[AXIS_W-1]) begin
                    m = '0;
                end else if (cs >= ns) begin
                    m = ns - AXIS_W'(1);
                end
            end
            BORDER_REPEAT: begin
                m = cs % ns;
                if (m[AXIS_W-1]) begin
                    m = m + ns;
                end
            end
            default: begin
                // mirror: fold the 2n period back onto 0..n-1
                m = cs % n2;
                if (m[AXIS_W-1]) begin
                    m = m + n2;
                end
                if (m >= ns) begin
                    m = n2 - AXIS_W'(1) - m;
                end
            end
        endcase
        return {border, m[`TEX_ADDR_W-1:0]};
    endfunction

    logic [`TEX_ADDR_W:0] x_map;
    logic [`TEX_ADDR_W:0] y_map;

    assign x_map = map_axis(round_coord(in_x), width, x_op);
    assign y_map = map_axis(round_coord(in_y), height, y_op);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
        out_addr   <= {y_map[`TEX_ADDR_W-1:0], x_map[`TEX_ADDR_W-1:0]};
        out_border <= x_map[`TEX_ADDR_W] | y_map[`TEX_ADDR_W];
    end

endmodule

// ==== logic/tex_consts.svh ====
// texture sampler constants
// widths, sizes and port count shared by the packages and the RTL

`ifndef TEX_CONSTS_SVH
`define TEX_CONSTS_SVH

// --------------------------------------------------
// sampler ports
// --------------------------------------------------

`define TEX_PORTS 2

// --------------------------------------------------
// coordinates
// --------------------------------------------------

// texel index per axis, 16 texels max
`define TEX_ADDR_W 4
// signed integer part of a sample coordinate
`define TEX_INT_W 6
`define TEX_FRAC_W 4

// --------------------------------------------------
// texel format and queueing
// --------------------------------------------------

`define TEX_COMP_W 8
`define TEX_COMP_NUM 3
// entries per port request queue
`define TEX_QUEUE_DEPTH 4

`endif

// ==== logic/tex_coord_pkg.sv ====
// texture coordinate types
// fixed point sample coordinates, rounded texel coordinates,
// texture sizes and the per-axis border operations

`include "tex_consts.svh"

package tex_coord_pkg;

    // 6.4 signed fixed point
    typedef logic signed [`TEX_INT_W+`TEX_FRAC_W-1:0] coord_t;

    // coordinate after rounding to the nearest texel
    typedef logic signed [`TEX_INT_W-1:0] int_coord_t;

    // width or height, 1 to 16
    typedef logic [`TEX_ADDR_W:0] size_t;

    // what to do with a coordinate outside the texture
    typedef enum logic [1:0] {
        BORDER_CONST  = 2'd0,
        BORDER_CLAMP  = 2'd1,
        BORDER_REPEAT = 2'd2,
        BORDER_MIRROR = 2'd3
    } border_op_e;

endpackage

// ==== logic/tex_mem_arbiter.sv ====
// texel memory arbiter
// round robin between the two sampler ports, one grant per cycle,
// steers the read data back to the granted port two cycles later

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_mem_arbiter
    import tex_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req         [`TEX_PORTS],
    input  texel_addr_t req_addr    [`TEX_PORTS],
    output logic        grant       [`TEX_PORTS],
    output logic        rd_en,
    output texel_addr_t rd_addr,
    input  texel_t      rd_data_mem,
    output logic        rd_valid    [`TEX_PORTS],
    output texel_t      rd_data
);

    arb_state_e state;
    port_sel_t  gnt_id;
    logic       gnt_any;

    // --------------------------------------------------
    // grant
    // --------------------------------------------------

    // preferred port wins a conflict, otherwise any requester is served
    assign grant[0] = req[0] && (state == ARB_PREFER_0 || !req[1]);
    assign grant[1] = req[1] && (state == ARB_PREFER_1 || !req[0]);
    assign gnt_any  = grant[0] | grant[1];
    assign gnt_id   = port_sel_t'(grant[1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARB_PREFER_0;
        end else if (gnt_any) begin
            // last served port drops to low priority
            state <= (gnt_id == port_sel_t'(0)) ? ARB_PREFER_1 : ARB_PREFER_0;
        end
    end

    // --------------------------------------------------
    // read pipeline, port id follows the request
    // --------------------------------------------------

    port_sel_t sel_q;
    port_sel_t sel_q2;
    logic      valid_q2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_en    <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            rd_en    <= gnt_any;
            valid_q2 <= rd_en;
        end
        rd_addr <= req_addr[gnt_id];
        sel_q   <= gnt_id;
        sel_q2  <= sel_q;
    end

    assign rd_valid[0] = valid_q2 && (sel_q2 == port_sel_t'(0));
    assign rd_valid[1] = valid_q2 && (sel_q2 == port_sel_t'(1));
    assign rd_data     = rd_data_mem;

    // a port that loses a conflict is served on the next cycle
    a_fair_0: assert property (@(posedge clk) disable iff (!rst_n)
        req[0] && !grant[0] |=> grant[0]);

    a_fair_1: assert property (@(posedge clk) disable iff (!rst_n)
        req[1] && !grant[1] |=> grant[1]);

endmodule

// ==== logic/tex_mem_pkg.sv ====
// texel memory types
// texel format, memory address layout and arbiter priority state

`include "tex_consts.svh"

package tex_mem_pkg;

    // three 8-bit components
    typedef logic [`TEX_COMP_NUM*`TEX_COMP_W-1:0] texel_t;

    // row in the high half, column in the low half
    typedef logic [2*`TEX_ADDR_W-1:0] texel_addr_t;

    typedef logic [$clog2(`TEX_PORTS)-1:0] port_sel_t;

    // port that gets priority on the next conflict
    typedef enum logic {
        ARB_PREFER_0 = 1'b0,
        ARB_PREFER_1 = 1'b1
    } arb_state_e;

endpackage

// ==== logic/tex_memory.sv ====
// texel memory
// 16x16 texel RAM, one load write port and one registered read port

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_memory
    import tex_mem_pkg::*;
(
    input  logic        clk,
    input  logic        load_valid,
    input  texel_addr_t load_addr,
    input  texel_t      load_data,
    input  logic        rd_en,
    input  texel_addr_t rd_addr,
    output texel_t      rd_data
);

    localparam int DEPTH = 1 << (2 * `TEX_ADDR_W);

    // rows are fixed at 16 texels, address is {row, column}
    texel_t mem [DEPTH];

    // --------------------------------------------------
    // load port
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------

    // data one cycle after rd_en, held otherwise
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/tex_sampler_port.sv ====
// texture sampler port
// border unit, request queue towards the memory arbiter and
// assembly of the result from read data or the border value

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_sampler_port
    import tex_coord_pkg::*;
    import tex_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        s_valid,
    input  coord_t      s_x,
    input  coord_t      s_y,
    input  size_t       width,
    input  size_t       height,
    input  border_op_e  x_op,
    input  border_op_e  y_op,
    input  texel_t      border_value,
    output logic        req,
    output texel_addr_t req_addr,
    input  logic        grant,
    input  logic        rd_valid,
    input  texel_t      rd_data,
    output logic        m_valid,
    output texel_t      m_data,
    output logic        m_border
);

    localparam int PTR_W = $clog2(`TEX_QUEUE_DEPTH);

    logic        bu_valid;
    texel_addr_t bu_addr;
    logic        bu_border;

    tex_border_unit border_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (s_valid),
        .in_x       (s_x),
        .in_y       (s_y),
        .width      (width),
        .height     (height),
        .x_op       (x_op),
        .y_op       (y_op),
        .out_valid  (bu_valid),
        .out_addr   (bu_addr),
        .out_border (bu_border)
    );

    // --------------------------------------------------
    // request queue
    // --------------------------------------------------

    texel_addr_t      q_addr   [`TEX_QUEUE_DEPTH];
    logic             q_border [`TEX_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;

    assign full     = (count == (PTR_W+1)'(`TEX_QUEUE_DEPTH));
    assign req      = (count != '0);
    assign req_addr = q_addr[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (bu_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (grant) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({bu_valid, grant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
        if (bu_valid) begin
            q_addr[wr_ptr]   <= bu_addr;
            q_border[wr_ptr] <= bu_border;
        end
    end

    // --------------------------------------------------
    // in-flight border flag and result
    // --------------------------------------------------

    // stage 1 holds the flag of this cycle's grant, stage 2 lines up with rd_valid
    logic flight_border_q [2];

    always_ff @(posedge clk) begin
        flight_border_q[0] <= grant & q_border[rd_ptr];
        flight_border_q[1] <= flight_border_q[0];
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= rd_valid;
        end
        m_data   <= flight_border_q[1] ? border_value : rd_data;
        m_border <= flight_border_q[1];
    end

    // driver keeps to one strobe every 2 cycles, queue must never overflow
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(bu_valid && full && !grant));

    // read data comes back exactly two cycles after our grant
    a_grant_latency: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> ##2 rd_valid);

endmodule

// ==== logic/tex_sampler_top.sv ====
// texture sampler top
// two nearest-texel sampler ports sharing one texel memory

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_sampler_top
    import tex_coord_pkg::*;
    import tex_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // texture load
    input  logic        load_valid,
    input  texel_addr_t load_addr,
    input  texel_t      load_data,
    // configuration, static while samples are in flight
    input  size_t       param_width,
    input  size_t       param_height,
    input  border_op_e  param_x_op,
    input  border_op_e  param_y_op,
    input  texel_t      param_border_value,
    // samples
    input  logic        s_valid  [`TEX_PORTS],
    input  coord_t      s_x      [`TEX_PORTS],
    input  coord_t      s_y      [`TEX_PORTS],
    output logic        m_valid  [`TEX_PORTS],
    output texel_t      m_data   [`TEX_PORTS],
    output logic        m_border [`TEX_PORTS]
);

    logic        req      [`TEX_PORTS];
    texel_addr_t req_addr [`TEX_PORTS];
    logic        grant    [`TEX_PORTS];
    logic        rd_valid [`TEX_PORTS];
    texel_t      rd_data;
    logic        rd_en;
    texel_addr_t rd_addr;
    texel_t      mem_rd_data;

    // --------------------------------------------------
    // sampler ports
    // --------------------------------------------------

    for (genvar p = 0; p < `TEX_PORTS; p++) begin : g_port
        tex_sampler_port port_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .s_valid      (s_valid[p]),
            .s_x          (s_x[p]),
            .s_y          (s_y[p]),
            .width        (param_width),
            .height       (param_height),
            .x_op         (param_x_op),
            .y_op         (param_y_op),
            .border_value (param_border_value),
            .req          (req[p]),
            .req_addr     (req_addr[p]),
            .grant        (grant[p]),
            .rd_valid     (rd_valid[p]),
            .rd_data      (rd_data),
            .m_valid      (m_valid[p]),
            .m_data       (m_data[p]),
            .m_border     (m_border[p])
        );
    end

    // --------------------------------------------------
    // shared memory
    // --------------------------------------------------

    tex_mem_arbiter arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_addr    (req_addr),
        .grant       (grant),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data_mem (mem_rd_data),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    tex_memory memory_i (
        .clk        (clk),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (mem_rd_data)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the texture sampler testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tex_sampler_tb -f filelist.f

status=0
./obj_dir/Vtex_sampler_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a pass result"
    exit 1
fi

// ==== tests/tex_clock_gen.sv ====
// testbench clock and reset
// 100 ns clock, rst_n held low for 5 cycles and released on a falling edge

`timescale 1ns/1ns

module tex_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tex_golden.hex ====
// texel count, then {addr, texel} words, texel at row r col c is {rc, rc, 3C}
18
0000003C 0101013C 0202023C 0303033C 0404043C 0505053C
1010103C 1111113C 1212123C 1313133C 1414143C 1515153C
2020203C 2121213C 2222223C 2323233C 2424243C 2525253C
3030303C 3131313C 3232323C 3333333C 3434343C 3535353C
// record count, then: id x_op y_op width height border port x y exp_data exp_border
24
01 1 1 06 04 000000 0 020 010 12123C 0
01 1 1 06 04 000000 1 050 030 35353C 0
01 1 1 06 04 000000 0 000 000 00003C 0
01 1 1 06 04 000000 1 030 020 23233C 0
02 0 0 06 04 BEEF01 0 018 007 02023C 0
02 0 0 06 04 BEEF01 1 027 028 32323C 0
02 0 0 06 04 BEEF01 0 3F8 019 20203C 0
02 0 0 06 04 BEEF01 1 3F6 010 BEEF01 1
02 0 0 06 04 BEEF01 0 057 037 35353C 0
02 0 0 06 04 BEEF01 1 058 000 BEEF01 1
03 0 0 05 03 A5A5A5 0 050 000 A5A5A5 1
03 0 0 05 03 A5A5A5 1 010 030 A5A5A5 1
03 0 0 05 03 A5A5A5 0 3F0 3E0 A5A5A5 1
03 0 0 05 03 A5A5A5 1 040 020 24243C 0
04 1 1 05 03 000000 0 090 3D0 04043C 0
04 1 1 05 03 000000 1 390 060 20203C 0
04 1 1 05 03 000000 0 140 030 24243C 0
05 2 2 05 03 000000 0 070 040 12123C 0
05 2 2 05 03 000000 1 3F0 3C0 24243C 0
05 2 2 05 03 000000 0 360 050 20203C 0
05 2 2 05 03 000000 1 0D0 3D0 03033C 0
06 3 3 05 03 000000 0 050 030 24243C 0
06 3 3 05 03 000000 1 3F0 3F0 00003C 0
06 3 3 05 03 000000 0 0C0 070 12123C 0
06 3 3 05 03 000000 1 390 3B0 13133C 0
06 3 3 05 03 000000 0 080 040 11113C 0
07 1 1 06 04 000000 0 010 000 01013C 0
07 1 1 06 04 000000 1 020 000 02023C 0
07 1 1 06 04 000000 0 030 010 13133C 0
07 1 1 06 04 000000 1 040 010 14143C 0
07 1 1 06 04 000000 0 050 020 25253C 0
07 1 1 06 04 000000 1 000 020 20203C 0
07 1 1 06 04 000000 0 010 030 31313C 0
07 1 1 06 04 000000 1 020 030 32323C 0
07 1 1 06 04 000000 0 040 030 34343C 0
07 1 1 06 04 000000 1 050 000 05053C 0

// ==== tests/tex_sampler_tb.sv ====
// texture sampler testbench
// loads the texture from the golden file, replays its sample records
// on both ports and checks every result in order per port

`timescale 1ns/1ns
`include "tex_consts.svh"

module tex_sampler_tb
    import tex_coord_pkg::*;
    import tex_mem_pkg::*;
();

    localparam int GOLDEN_WORDS   = 512;
    localparam int REC_WORDS      = 11;
    localparam int TIMEOUT_CYCLES = 200;

    // record layout in the golden file
    localparam int F_ID         = 0;
    localparam int F_XOP        = 1;
    localparam int F_YOP        = 2;
    localparam int F_WIDTH      = 3;
    localparam int F_HEIGHT     = 4;
    localparam int F_BORDER_VAL = 5;
    localparam int F_PORT       = 6;
    localparam int F_X          = 7;
    localparam int F_Y          = 8;
    localparam int F_EXP_DATA   = 9;
    localparam int F_EXP_BORDER = 10;

    logic        clk;
    logic        rst_n;
    logic        load_valid;
    texel_addr_t load_addr;
    texel_t      load_data;
    size_t       param_width;
    size_t       param_height;
    border_op_e  param_x_op;
    border_op_e  param_y_op;
    texel_t      param_border_value;
    logic        s_valid  [`TEX_PORTS];
    coord_t      s_x      [`TEX_PORTS];
    coord_t      s_y      [`TEX_PORTS];
    logic        m_valid  [`TEX_PORTS];
    texel_t      m_data   [`TEX_PORTS];
    logic        m_border [`TEX_PORTS];

    logic [31:0] golden [0:GOLDEN_WORDS-1];
    // expected {border, data} per port, oldest first
    logic [24:0] exp_q0 [$];
    logic [24:0] exp_q1 [$];

    int seed = 32'h5b34_e148;
    int rec_base;
    int rec_count;
    int fail_count;
    int check_count;
    int test_errors;
    int tests_passed;
    int tests_failed;
    bit timed_out;

    tex_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tex_sampler_top dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .load_valid         (load_valid),
        .load_addr          (load_addr),
        .load_data          (load_data),
        .param_width        (param_width),
        .param_height       (param_height),
        .param_x_op         (param_x_op),
        .param_y_op         (param_y_op),
        .param_border_value (param_border_value),
        .s_valid            (s_valid),
        .s_x                (s_x),
        .s_y                (s_y),
        .m_valid            (m_valid),
        .m_data             (m_data),
        .m_border           (m_border)
    );

    // --------------------------------------------------
    // golden file access
    // --------------------------------------------------

    function automatic logic [31:0] field(input int rec, input int f);
        return golden[rec_base + rec * REC_WORDS + f];
    endfunction

    function automatic int port_of(input int rec);
        logic [31:0] w;
        w = field(rec, F_PORT);
        return int'(w[0]);
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic clear_strobes();
        for (int p = 0; p < `TEX_PORTS; p++) begin
            s_valid[p] = 1'b0;
        end
    endtask

    task automatic load_texture(input int tex_count);
        logic [31:0] w;
        for (int i = 0; i < tex_count; i++) begin
            @(negedge clk);
            w          = golden[1 + i];
            load_valid = 1'b1;
            load_addr  = w[31:24];
            load_data  = w[23:0];
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic configure(input int rec);
        logic [31:0] w;
        @(negedge clk);
        w = field(rec, F_XOP);
        param_x_op = border_op_e'(w[1:0]);
        w = field(rec, F_YOP);
        param_y_op = border_op_e'(w[1:0]);
        w = field(rec, F_WIDTH);
        param_width = w[4:0];
        w = field(rec, F_HEIGHT);
        param_height = w[4:0];
        w = field(rec, F_BORDER_VAL);
        param_border_value = w[23:0];
    endtask

    task automatic issue_sample(input int rec);
        int          p;
        logic [31:0] x_word;
        logic [31:0] y_word;
        logic [31:0] data_word;
        logic [31:0] border_word;
        p           = port_of(rec);
        x_word      = field(rec, F_X);
        y_word      = field(rec, F_Y);
        data_word   = field(rec, F_EXP_DATA);
        border_word = field(rec, F_EXP_BORDER);
        s_valid[p]  = 1'b1;
        s_x[p]      = x_word[9:0];
        s_y[p]      = y_word[9:0];
        if (p == 0) begin
            exp_q0.push_back({border_word[0], data_word[23:0]});
        end else begin
            exp_q1.push_back({border_word[0], data_word[23:0]});
        end
    endtask

    // one strobe per port every 2 cycles at most, both ports may share a cycle
    task automatic drive_test(input int first, input int last);
        int rec;
        int p;
        bit busy [2];
        bit used [2];
        rec     = first;
        busy[0] = 1'b0;
        busy[1] = 1'b0;
        while (rec <= last) begin
            @(negedge clk);
            clear_strobes();
            used[0] = 1'b0;
            used[1] = 1'b0;
            if (($random(seed) & 3) == 0) begin
                busy = used;
            end else begin
                p = port_of(rec);
                while (rec <= last && !busy[p] && !used[p]) begin
                    issue_sample(rec);
                    used[p] = 1'b1;
                    rec++;
                    if (rec <= last) begin
                        p = port_of(rec);
                    end
                end
                busy = used;
            end
        end
        @(negedge clk);
        clear_strobes();
    endtask

    // --------------------------------------------------
    // waits
    // --------------------------------------------------

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("reset was never released after %0d cycles", cycles);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("results still missing after %0d cycles (port 0: %0d, port 1: %0d)",
                         cycles, exp_q0.size(), exp_q1.size());
                timed_out = 1'b1;
            end
        end
        // catch stray results behind the last one
        @(negedge clk);
        // checks of that falling edge are done by the next rising edge
        @(posedge clk);
    endtask

    // --------------------------------------------------
    // result checking
    // --------------------------------------------------

    task automatic check_port(input int p);
        logic [24:0] exp;
        int          pending;
        pending = (p == 0) ? exp_q0.size() : exp_q1.size();
        if (pending == 0) begin
            $display("port %0d returned a result at %0t with no sample outstanding", p, $time);
            test_errors++;
        end else begin
            if (p == 0) begin
                exp = exp_q0.pop_front();
            end else begin
                exp = exp_q1.pop_front();
            end
            check_count++;
            if (m_data[p] !== exp[23:0] || m_border[p] !== exp[24]) begin
                $display("FAIL %0t: port %0d got %h border %b, expected %h border %b",
                         $time, p, m_data[p], m_border[p], exp[23:0], exp[24]);
                test_errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < `TEX_PORTS; p++) begin
                if (m_valid[p]) begin
                    check_port(p);
                end
            end
        end
    end

    task automatic run_test(input int first, input int last);
        int id;
        id          = int'(field(first, F_ID));
        test_errors = 0;
        configure(first);
        drive_test(first, last);
        wait_drain();
        if (test_errors == 0 && !timed_out) begin
            tests_passed++;
            $display("test %0d passed, %0d samples", id, last - first + 1);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d errors", id, test_errors);
        end
        fail_count += test_errors;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        int tex_count;
        int i;
        int last;
        load_valid         = 1'b0;
        load_addr          = '0;
        load_data          = '0;
        param_width        = 5'd1;
        param_height       = 5'd1;
        param_x_op         = BORDER_CLAMP;
        param_y_op         = BORDER_CLAMP;
        param_border_value = '0;
        for (int p = 0; p < `TEX_PORTS; p++) begin
            s_valid[p] = 1'b0;
            s_x[p]     = '0;
            s_y[p]     = '0;
        end
        rec_count = 0;
        $readmemh("tests/tex_golden.hex", golden);
        if ($isunknown(golden[0])) begin
            $display("golden file could not be read");
            fail_count++;
        end else begin
            tex_count = int'(golden[0]);
            rec_count = int'(golden[1 + tex_count]);
            rec_base  = 2 + tex_count;
        end
        wait_reset();
        if (!timed_out && rec_count > 0) begin
            load_texture(tex_count);
        end
        i = 0;
        while (i < rec_count && !timed_out) begin
            last = i;
            while (last + 1 < rec_count && field(last + 1, F_ID) == field(i, F_ID)) begin
                last++;
            end
            run_test(i, last);
            i = last + 1;
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, fail_count);
        if (fail_count == 0 && tests_failed == 0 && !timed_out && tests_passed > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
